//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_load_store_unit
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/data_port.sv
`default_nettype none
`timescale 1ns/100ps

module data_port #(
  parameter int TIMEOUT_CYCLES = 10
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         dreq_i,
  input  wire  lsu_pkg::mem_op_e      dop_i,
  input  wire  [lsu_pkg::XLEN-1:0]    daddr_i,
  input  wire  [lsu_pkg::XLEN-1:0]    dwdata_i,
  input  wire  lsu_pkg::wb_rsp_t      dbus_rsp_i,
  output lsu_pkg::wb_req_t            dbus_req_o,
  output logic [lsu_pkg::XLEN-1:0]    drdata_o,
  output logic                        ddone_o,
  output logic                        dmisalign_o,
  output logic                        dberr_o,
  output logic                        dabort_o,
  output logic                        dbusy_o
);

  import lsu_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operation decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Access sizes.
  localparam logic [1:0] SZ_BYTE = 2'd0;
  localparam logic [1:0] SZ_HALF = 2'd1;
  localparam logic [1:0] SZ_WORD = 2'd2;

  // Same counter sizing as on the fetch side.
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES);
  localparam logic [CNT_W-1:0] TMO_LAST = CNT_W'(TIMEOUT_CYCLES - 1);

  // What an operation means for the bus and for the returned data.
  typedef struct packed {
    logic       store;
    logic       sgn;
    logic [1:0] size;
  } op_info_t;

  function automatic op_info_t decode_op(input mem_op_e op);
    op_info_t info;
    info = '{store: 1'b0, sgn: 1'b0, size: SZ_WORD};
    case (op)
      MEM_LB:  info = '{store: 1'b0, sgn: 1'b1, size: SZ_BYTE};
      MEM_LH:  info = '{store: 1'b0, sgn: 1'b1, size: SZ_HALF};
      MEM_LW:  info = '{store: 1'b0, sgn: 1'b0, size: SZ_WORD};
      MEM_LBU: info = '{store: 1'b0, sgn: 1'b0, size: SZ_BYTE};
      MEM_LHU: info = '{store: 1'b0, sgn: 1'b0, size: SZ_HALF};
      MEM_SB:  info = '{store: 1'b1, sgn: 1'b0, size: SZ_BYTE};
      MEM_SH:  info = '{store: 1'b1, sgn: 1'b0, size: SZ_HALF};
      default: info = '{store: 1'b1, sgn: 1'b0, size: SZ_WORD};
    endcase
    return info;
  endfunction

  port_state_e      state;
  op_info_t         req_info;
  op_info_t         q_info;
  mem_op_e          op_q;
  logic [XLEN-1:0]  adr_q;
  logic [XLEN-1:0]  dat_q;
  logic [SEL_W-1:0] sel_q;
  logic             we_q;
  logic [CNT_W-1:0] tmo_cnt;
  logic             req_misalign;
  logic [SEL_W-1:0] req_sel;
  logic [XLEN-1:0]  req_wdata;
  logic [7:0]       lane_b;
  logic [15:0]      lane_h;
  logic [XLEN-1:0]  load_data;
  logic             bus_on;
  logic             accept;

  // The incoming request is decoded here, the registered one further down.
  assign req_info = decode_op(dop_i);
  assign q_info   = decode_op(op_q);
  assign bus_on   = (state == ST_BUS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Alignment, lanes and store data
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Bytes never misalign. Halfwords need an even address, words a multiple of four.
  always_comb begin
    req_misalign = 1'b0;
    req_sel      = '1;
    req_wdata    = dwdata_i;
    case (req_info.size)
      SZ_BYTE: begin
        req_sel   = SEL_W'(1) << daddr_i[1:0];
        req_wdata = {(XLEN / 8){dwdata_i[7:0]}};
      end
      SZ_HALF: begin
        req_misalign = daddr_i[0];
        req_sel      = daddr_i[1] ? 4'b1100 : 4'b0011;
        req_wdata    = {(XLEN / 16){dwdata_i[15:0]}};
      end
      default: begin
        req_misalign = (daddr_i[1:0] != 2'b00);
      end
    endcase
  end

  // A bus cycle starts only for an aligned request seen while idle.
  assign accept = (state == ST_IDLE) && dreq_i && !req_misalign;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load lane extraction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The lane is picked with the address captured at the start of the cycle.
  assign lane_b = dbus_rsp_i.dat[{adr_q[1:0], 3'b000} +: 8];
  assign lane_h = dbus_rsp_i.dat[{adr_q[1], 4'b0000} +: 16];

  always_comb begin
    case (q_info.size)
      SZ_BYTE: load_data = {{(XLEN - 8){q_info.sgn & lane_b[7]}}, lane_b};
      SZ_HALF: load_data = {{(XLEN - 16){q_info.sgn & lane_h[15]}}, lane_h};
      default: load_data = dbus_rsp_i.dat;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus request and status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    dbus_req_o     = '0;
    dbus_req_o.adr = adr_q;
    dbus_req_o.dat = dat_q;
    dbus_req_o.sel = sel_q;
    dbus_req_o.cyc = bus_on;
    dbus_req_o.stb = bus_on;
    dbus_req_o.we  = we_q;
  end

  assign dbusy_o  = bus_on;
  assign dabort_o = (state == ST_ABORT);  // sticky until reset

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      we_q        <= 1'b0;
      tmo_cnt     <= '0;
      ddone_o     <= 1'b0;
      dmisalign_o <= 1'b0;
      dberr_o     <= 1'b0;
    end else begin
      ddone_o     <= 1'b0;
      dmisalign_o <= 1'b0;
      dberr_o     <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (dreq_i && req_misalign) begin
            dmisalign_o <= 1'b1;
          end else if (accept) begin
            state   <= ST_BUS;
            we_q    <= req_info.store;
            tmo_cnt <= '0;
          end
        end
        ST_BUS: begin
          // An error ends the cycle like an acknowledge, with dberr_o set.
          if (dbus_rsp_i.ack || dbus_rsp_i.err) begin
            ddone_o <= 1'b1;
            dberr_o <= dbus_rsp_i.err;
            we_q    <= 1'b0;
            state   <= ST_IDLE;
          end else if (tmo_cnt == TMO_LAST) begin
            we_q  <= 1'b0;
            state <= ST_ABORT;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        ST_ABORT: begin
          state <= ST_ABORT;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Payload is captured at the start and held for the whole cycle.
  // Read data only moves on an acknowledged load without an error.
  always_ff @(posedge clk) begin
    if (accept) begin
      adr_q <= daddr_i;
      dat_q <= req_wdata;
      sel_q <= req_sel;
      op_q  <= dop_i;
    end
    if (bus_on && dbus_rsp_i.ack && !dbus_rsp_i.err && !we_q) begin
      drdata_o <= load_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_port.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_port #(
  parameter int TIMEOUT_CYCLES = 10
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         fetch_i,
  input  wire  [lsu_pkg::XLEN-1:0]    pc_i,
  input  wire  lsu_pkg::wb_rsp_t      ibus_rsp_i,
  output lsu_pkg::wb_req_t            ibus_req_o,
  output logic [lsu_pkg::XLEN-1:0]    instr_o,
  output logic                        ready_o,
  output logic                        if_stall_o,
  output logic                        xint_o,
  output logic                        abort_o,
  output logic                        no_mem_o
);

  import lsu_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Timeout counter sizing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The counter holds the number of unacknowledged cycles seen so far.
  // It never needs to reach TIMEOUT_CYCLES itself, so clog2 bits suffice.
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES);

  // Count value in the last unacknowledged cycle before the abort.
  localparam logic [CNT_W-1:0] TMO_LAST = CNT_W'(TIMEOUT_CYCLES - 1);

  port_state_e      state;
  logic [XLEN-1:0]  adr_q;
  logic [CNT_W-1:0] tmo_cnt;
  logic             pc_misalign;
  logic             bus_on;

  // Instructions are whole words, so the two low pc bits must be zero.
  assign pc_misalign = (pc_i[1:0] != 2'b00);

  // A bus cycle is open for exactly as long as the FSM sits in ST_BUS.
  assign bus_on = (state == ST_BUS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The fetch bus only ever reads whole words.
  // cyc and stb rise and fall together with the state register.
  always_comb begin
    ibus_req_o     = '0;
    ibus_req_o.adr = adr_q;
    ibus_req_o.sel = '1;
    ibus_req_o.cyc = bus_on;
    ibus_req_o.stb = bus_on;
    ibus_req_o.we  = 1'b0;
  end

  // The core stalls while a fetch is outstanding.
  assign if_stall_o = bus_on;

  // Abort and no-memory are both sticky and mark the same condition.
  assign abort_o  = (state == ST_ABORT);
  assign no_mem_o = (state == ST_ABORT);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      tmo_cnt <= '0;
      ready_o <= 1'b0;
      xint_o  <= 1'b0;
    end else begin
      // Result flags are single-cycle pulses.
      ready_o <= 1'b0;
      xint_o  <= 1'b0;
      case (state)
        ST_IDLE: begin
          // A strobe is only honoured here; in any other state it is dropped.
          if (fetch_i) begin
            if (pc_misalign) begin
              xint_o <= 1'b1;
            end else begin
              state   <= ST_BUS;
              tmo_cnt <= '0;
            end
          end
        end
        ST_BUS: begin
          if (ibus_rsp_i.ack) begin
            ready_o <= 1'b1;
            state   <= ST_IDLE;
          end else if (ibus_rsp_i.err) begin
            // A bus error on fetch is reported as an instruction exception.
            xint_o <= 1'b1;
            state  <= ST_IDLE;
          end else if (tmo_cnt == TMO_LAST) begin
            // Nothing answered in time, so there is no memory behind the bus.
            state <= ST_ABORT;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        ST_ABORT: begin
          state <= ST_ABORT;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address and instruction registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The pc is captured when a cycle starts and held for the whole cycle.
  // The instruction word is taken from the bus on the acknowledge.
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && fetch_i && !pc_misalign) begin
      adr_q <= pc_i;
    end
    if (bus_on && ibus_rsp_i.ack) begin
      instr_o <= ibus_rsp_i.dat;
    end
  end

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
`default_nettype none
`timescale 1ns/100ps

module load_store_unit #(
  parameter int TIMEOUT_CYCLES = 10
) (
  input  wire                         clk,
  input  wire                         rst,
  // Instruction side.
  input  wire                         fetch_i,
  input  wire  [lsu_pkg::XLEN-1:0]    pc_i,
  input  wire  lsu_pkg::wb_rsp_t      ibus_rsp_i,
  output lsu_pkg::wb_req_t            ibus_req_o,
  output logic [lsu_pkg::XLEN-1:0]    instr_o,
  output logic                        ready_o,
  output logic                        if_stall_o,
  output logic                        xint_o,
  output logic                        abort_o,
  output logic                        no_mem_o,
  // Data side.
  input  wire                         dreq_i,
  input  wire  lsu_pkg::mem_op_e      dop_i,
  input  wire  [lsu_pkg::XLEN-1:0]    daddr_i,
  input  wire  [lsu_pkg::XLEN-1:0]    dwdata_i,
  input  wire  lsu_pkg::wb_rsp_t      dbus_rsp_i,
  output lsu_pkg::wb_req_t            dbus_req_o,
  output logic [lsu_pkg::XLEN-1:0]    drdata_o,
  output logic                        ddone_o,
  output logic                        dmisalign_o,
  output logic                        dberr_o,
  output logic                        dabort_o,
  output logic                        dbusy_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction fetch master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The two masters sit on separate buses and never interact.
  fetch_port #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_fetch (
    .clk        (clk),
    .rst        (rst),
    .fetch_i    (fetch_i),
    .pc_i       (pc_i),
    .ibus_rsp_i (ibus_rsp_i),
    .ibus_req_o (ibus_req_o),
    .instr_o    (instr_o),
    .ready_o    (ready_o),
    .if_stall_o (if_stall_o),
    .xint_o     (xint_o),
    .abort_o    (abort_o),
    .no_mem_o   (no_mem_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data load and store master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Both ports share the one timeout value set here.
  data_port #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_data (
    .clk         (clk),
    .rst         (rst),
    .dreq_i      (dreq_i),
    .dop_i       (dop_i),
    .daddr_i     (daddr_i),
    .dwdata_i    (dwdata_i),
    .dbus_rsp_i  (dbus_rsp_i),
    .dbus_req_o  (dbus_req_o),
    .drdata_o    (drdata_o),
    .ddone_o     (ddone_o),
    .dmisalign_o (dmisalign_o),
    .dberr_o     (dberr_o),
    .dabort_o    (dabort_o),
    .dbusy_o     (dbusy_o)
  );

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data and address width of the core, one machine word.
  localparam int XLEN = 32;

  // One byte-lane select bit per byte of the word.
  localparam int SEL_W = XLEN / 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone classic bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Master to slave. The address is a byte address.
  // The slave uses sel to pick the lanes of the word at adr.
  typedef struct packed {
    logic [XLEN-1:0]  adr;
    logic [XLEN-1:0]  dat;
    logic [SEL_W-1:0] sel;
    logic             cyc;
    logic             stb;
    logic             we;
  } wb_req_t;

  // Slave to master. Exactly one of ack and err ends a cycle.
  typedef struct packed {
    logic [XLEN-1:0] dat;
    logic            ack;
    logic            err;
  } wb_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operations and states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data-side operations, loads first and then stores.
  typedef enum logic [2:0] {
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_LBU,
    MEM_LHU,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_op_e;

  // Bus master state, shared by the fetch and the data port.
  // ST_ABORT is left only by reset.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_ABORT
  } port_state_e;

endpackage

`default_nettype wire

//--- tb.f
logic/lsu_pkg.sv
logic/fetch_port.sv
logic/data_port.sv
logic/load_store_unit.sv
testbench/wb_mem_model.sv
testbench/lsu_assert.sv
testbench/tb_load_store_unit.sv

//--- testbench/lsu_assert.sv
`default_nettype none
`timescale 1ns/100ps

module lsu_assert (
  input wire                      clk,
  input wire                      rst,
  input wire lsu_pkg::wb_req_t    req_i,
  input wire                      abort_i
);

  // Wishbone classic raises stb only inside an open cycle.
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    req_i.stb |-> req_i.cyc)
    else $error("stb is high while cyc is low");

  // The master holds the whole request still until the cycle ends.
  req_stable: assert property (@(posedge clk) disable iff (rst)
    req_i.stb && $past(req_i.stb) |->
      $stable(req_i.adr) && $stable(req_i.dat) && $stable(req_i.sel) && $stable(req_i.we))
    else $error("request changed while stb was high");

  // Once aborted, only reset brings the port back.
  abort_sticky: assert property (@(posedge clk) disable iff (rst)
    abort_i |=> abort_i)
    else $error("abort flag dropped without reset");

endmodule

bind fetch_port lsu_assert u_fetch_assert (
  .clk     (clk),
  .rst     (rst),
  .req_i   (ibus_req_o),
  .abort_i (abort_o)
);

bind data_port lsu_assert u_data_assert (
  .clk     (clk),
  .rst     (rst),
  .req_i   (dbus_req_o),
  .abort_i (dabort_o)
);

`default_nettype wire

//--- testbench/tb_load_store_unit.sv
`default_nettype none
`timescale 1ns/100ps

module tb_load_store_unit;

  import lsu_pkg::*;

  localparam int TMO_WAIT  = 50;
  localparam int RES_NONE  = 0;
  localparam int RES_DONE  = 1;
  localparam int RES_EXC   = 2;
  localparam int RES_ABORT = 3;

  logic        clk;
  logic        rst;
  logic        fetch;
  logic [31:0] pc;
  logic        dreq;
  mem_op_e     dop;
  logic [31:0] daddr;
  logic [31:0] dwdata;
  wb_req_t     ibus_req;
  wb_rsp_t     ibus_rsp;
  wb_req_t     dbus_req;
  wb_rsp_t     dbus_rsp;
  logic [31:0] instr;
  logic        ready;
  logic        if_stall;
  logic        xint;
  logic        abort;
  logic        no_mem;
  logic [31:0] drdata;
  logic        ddone;
  logic        dmisalign;
  logic        dberr;
  logic        dabort;
  logic        dbusy;

  // Shadow copies of both memories, and the expectations of the current access.
  logic [31:0] ishadow [256];
  logic [31:0] dshadow [256];
  logic [31:0] rng;
  logic [31:0] exp_instr;
  logic [31:0] exp_rdata;
  logic        exp_berr;
  int          checks = 0;
  int          errors = 0;

  mem_op_e     load_ops [5]  = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
  mem_op_e     store_ops [3] = '{MEM_SB, MEM_SH, MEM_SW};
  mem_op_e     mis_ops [4]   = '{MEM_LH, MEM_LW, MEM_SH, MEM_SW};
  logic [31:0] mis_addr [4]  = '{32'h0000_0101, 32'h0000_0102, 32'h0000_0103, 32'h0000_0105};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  load_store_unit #(
    .TIMEOUT_CYCLES (10)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .fetch_i     (fetch),
    .pc_i        (pc),
    .ibus_rsp_i  (ibus_rsp),
    .ibus_req_o  (ibus_req),
    .instr_o     (instr),
    .ready_o     (ready),
    .if_stall_o  (if_stall),
    .xint_o      (xint),
    .abort_o     (abort),
    .no_mem_o    (no_mem),
    .dreq_i      (dreq),
    .dop_i       (dop),
    .daddr_i     (daddr),
    .dwdata_i    (dwdata),
    .dbus_rsp_i  (dbus_rsp),
    .dbus_req_o  (dbus_req),
    .drdata_o    (drdata),
    .ddone_o     (ddone),
    .dmisalign_o (dmisalign),
    .dberr_o     (dberr),
    .dabort_o    (dabort),
    .dbusy_o     (dbusy)
  );

  // The instruction memory never answers err; the data memory does from 0x0F00.
  wb_mem_model #(.FILL_KEY(32'h0000_0000), .ERR_ENABLE(1'b0)) u_imem (
    .clk (clk), .rst (rst), .req_i (ibus_req), .rsp_o (ibus_rsp)
  );

  wb_mem_model #(.FILL_KEY(32'h5A3C_C3A5), .ERR_ENABLE(1'b1)) u_dmem (
    .clk (clk), .rst (rst), .req_i (dbus_req), .rsp_o (dbus_rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // Bits are shifted in low first, one LFSR step for each.
  task automatic draw(input int nbits, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < nbits; k++) begin
      val = {val[30:0], rng[0]};
      rng = lfsr_next(rng);
    end
  endtask

  function automatic logic is_store(input mem_op_e op);
    return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
  endfunction

  // Halfwords sit on even addresses and words on multiples of four.
  function automatic logic [31:0] align_for(input mem_op_e op, input logic [31:0] a);
    if (op == MEM_LW || op == MEM_SW) begin
      return a & ~32'h3;
    end else if (op == MEM_LH || op == MEM_LHU || op == MEM_SH) begin
      return a & ~32'h1;
    end
    return a;
  endfunction

  // Expected load result, or the new memory word after a store.
  // Byte 0 of a word is its least significant byte.
  function automatic logic [31:0] ref_access(input mem_op_e op, input logic [31:0] addr,
                                             input logic [31:0] wdata,
                                             input logic [31:0] word);
    logic [31:0] res;
    logic [7:0]  b;
    logic [15:0] h;
    int          boff;
    int          hoff;
    boff = 8 * int'(addr[1:0]);
    hoff = 16 * int'(addr[1]);
    b    = word[boff +: 8];
    h    = word[hoff +: 16];
    res  = word;
    case (op)
      MEM_LB:  res = {{24{b[7]}}, b};
      MEM_LH:  res = {{16{h[15]}}, h};
      MEM_LBU: res = {24'b0, b};
      MEM_LHU: res = {16'b0, h};
      MEM_SB:  res[boff +: 8] = wdata[7:0];
      MEM_SH:  res[hoff +: 16] = wdata[15:0];
      MEM_SW:  res = wdata;
      default: res = word;
    endcase
    return res;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
    errors++;
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
  endtask

  task automatic close_test(input string name, input int mark);
    $display("%-20s %s, %0d errors", name, (errors == mark) ? "passed" : "failed",
             errors - mark);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Expectations are set at a falling edge, and the strobe lasts one rising edge.
  // The stall level must stay high until the fetch ends.
  task automatic run_fetch(input logic [31:0] addr, output int result);
    int n;
    @(negedge clk);
    exp_instr = ishadow[addr[9:2]];
    @(posedge clk);
    fetch <= 1'b1;
    pc    <= addr;
    @(posedge clk);
    fetch <= 1'b0;
    result = RES_NONE;
    n      = 0;
    while (result == RES_NONE && n < TMO_WAIT) begin
      @(negedge clk);
      n++;
      if (ready) begin
        result = RES_DONE;
      end else if (xint) begin
        result = RES_EXC;
      end else if (abort) begin
        result = RES_ABORT;
      end else if (!if_stall) begin
        report_mismatch("if_stall_o during fetch", 32'(if_stall), 32'h1);
      end
    end
    if (result == RES_NONE) begin
      errors++;
      $display("Timeout: the fetch at %h never ended within %0d cycles", addr, TMO_WAIT);
    end
  endtask

  // Stores update the shadow word only once the memory has taken them.
  // A store or a failed load leaves the read data at the last load result.
  task automatic run_data(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic berr, output int result);
    int n;
    @(negedge clk);
    exp_berr = berr;
    if (!is_store(op) && !berr) begin
      exp_rdata = ref_access(op, addr, wdata, dshadow[addr[9:2]]);
    end
    @(posedge clk);
    dreq   <= 1'b1;
    dop    <= op;
    daddr  <= addr;
    dwdata <= wdata;
    @(posedge clk);
    dreq <= 1'b0;
    result = RES_NONE;
    n      = 0;
    while (result == RES_NONE && n < TMO_WAIT) begin
      @(negedge clk);
      n++;
      if (ddone) begin
        result = RES_DONE;
      end else if (dmisalign) begin
        result = RES_EXC;
      end else if (dabort) begin
        result = RES_ABORT;
      end else if (!dbusy) begin
        report_mismatch("dbusy_o during access", 32'(dbusy), 32'h1);
      end
    end
    if (result == RES_NONE) begin
      errors++;
      $display("Timeout: the data access at %h never ended within %0d cycles", addr, TMO_WAIT);
    end else if (result == RES_DONE && is_store(op) && !berr) begin
      dshadow[addr[9:2]] = ref_access(op, addr, wdata, dshadow[addr[9:2]]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Comparing process
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Results are sampled at the falling edge, half a cycle after they settle.
  always @(negedge clk) begin
    if (!rst && ready) begin
      checks++;
      if (instr !== exp_instr) begin
        report_mismatch("instr_o", instr, exp_instr);
      end
    end
    if (!rst && ddone) begin
      checks++;
      if (dberr !== exp_berr) begin
        report_mismatch("dberr_o", 32'(dberr), 32'(exp_berr));
      end
      if (drdata !== exp_rdata) begin
        report_mismatch("drdata_o", drdata, exp_rdata);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int          mark;
    int          result;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] w;
    rst    = 1'b1;
    fetch  = 1'b0;
    pc     = '0;
    dreq   = 1'b0;
    dop    = MEM_LW;
    daddr  = '0;
    dwdata = '0;
    rng    = 32'h9934;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      ishadow[i] = u_imem.mem[i];
      dshadow[i] = u_dmem.mem[i];
    end

    // Aligned fetches anywhere below 0x1000.
    mark = errors;
    for (int k = 0; k < 20; k++) begin
      draw(10, r);
      a = {20'b0, r[9:0], 2'b00};
      run_fetch(a, result);
      if (result != RES_DONE) begin
        report_mismatch("fetch result code", 32'(result), 32'(RES_DONE));
      end
    end
    close_test("aligned fetch", mark);

    // A misaligned pc raises the exception and opens no bus cycle.
    mark = errors;
    run_fetch(32'h0000_0106, result);
    if (result != RES_EXC) begin
      report_mismatch("misaligned fetch result code", 32'(result), 32'(RES_EXC));
    end
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (ibus_req.cyc || ready || xint) begin
        errors++;
        $display("Fail at %0t ns: bus activity after a misaligned fetch", $time);
      end
    end
    close_test("misaligned fetch", mark);

    // Every load size and signedness at random legal addresses.
    mark = errors;
    for (int o = 0; o < 5; o++) begin
      for (int k = 0; k < 4; k++) begin
        draw(10, r);
        a = align_for(load_ops[o], {22'b0, r[9:0]});
        run_data(load_ops[o], a, 32'h0, 1'b0, result);
        if (result != RES_DONE) begin
          report_mismatch("load result code", 32'(result), 32'(RES_DONE));
        end
      end
    end
    close_test("loads", mark);

    // Each store is read back as a whole word.
    mark = errors;
    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < 4; k++) begin
        draw(10, r);
        a = align_for(store_ops[o], {22'b0, r[9:0]});
        draw(32, w);
        run_data(store_ops[o], a, w, 1'b0, result);
        if (result != RES_DONE) begin
          report_mismatch("store result code", 32'(result), 32'(RES_DONE));
        end
        run_data(MEM_LW, a & ~32'h3, 32'h0, 1'b0, result);
        if (result != RES_DONE) begin
          report_mismatch("read-back result code", 32'(result), 32'(RES_DONE));
        end
      end
    end
    for (int k = 0; k < 4; k++) begin
      run_data(mis_ops[k], mis_addr[k], 32'hDEAD_BEEF, 1'b0, result);
      if (result != RES_EXC) begin
        report_mismatch("misaligned access result code", 32'(result), 32'(RES_EXC));
      end
      run_data(MEM_LW, mis_addr[k] & ~32'h3, 32'h0, 1'b0, result);
      if (result != RES_DONE) begin
        report_mismatch("read-back result code", 32'(result), 32'(RES_DONE));
      end
    end
    close_test("stores", mark);

    // The err region ends the cycle with dberr_o and leaves the port usable.
    mark = errors;
    run_data(MEM_LW, 32'h0000_0F40, 32'h0, 1'b1, result);
    if (result != RES_DONE) begin
      report_mismatch("err load result code", 32'(result), 32'(RES_DONE));
    end
    @(negedge clk);
    checks++;
    if (dbusy || dabort) begin
      errors++;
      $display("Fail at %0t ns: data port not idle after a bus error", $time);
    end
    run_data(MEM_LBU, 32'h0000_0013, 32'h0, 1'b0, result);
    if (result != RES_DONE) begin
      report_mismatch("load after err result code", 32'(result), 32'(RES_DONE));
    end
    close_test("bus error", mark);

    // No memory at 0x1000, so both ports abort and stay dead.
    mark = errors;
    run_fetch(32'h0000_1000, result);
    if (result != RES_ABORT) begin
      report_mismatch("fetch abort result code", 32'(result), 32'(RES_ABORT));
    end
    if (!no_mem) begin
      report_mismatch("no_mem_o after abort", 32'(no_mem), 32'h1);
    end
    @(posedge clk);
    fetch <= 1'b1;
    pc    <= 32'h0000_0020;
    @(posedge clk);
    fetch <= 1'b0;
    run_data(MEM_LW, 32'h0000_1000, 32'h0, 1'b0, result);
    if (result != RES_ABORT) begin
      report_mismatch("data abort result code", 32'(result), 32'(RES_ABORT));
    end
    @(posedge clk);
    dreq  <= 1'b1;
    daddr <= 32'h0000_0020;
    @(posedge clk);
    dreq <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (if_stall || ibus_req.cyc || !abort || !no_mem) begin
        errors++;
        $display("Fail at %0t ns: fetch port left the abort state", $time);
      end
      if (dbusy || dbus_req.cyc || !dabort) begin
        errors++;
        $display("Fail at %0t ns: data port left the abort state", $time);
      end
    end
    close_test("abort", mark);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/wb_mem_model.sv
`default_nettype none
`timescale 1ns/100ps

module wb_mem_model #(
  parameter logic [31:0] SEED       = 32'h9934,
  parameter logic [31:0] FILL_KEY   = 32'h0000_0000,
  parameter bit          ERR_ENABLE = 1'b0
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire  lsu_pkg::wb_req_t req_i,
  output lsu_pkg::wb_rsp_t       rsp_o
);

  import lsu_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The 256 words repeat below DEAD_BASE, and nothing answers from DEAD_BASE up.
  localparam int          WORDS     = 256;
  localparam logic [31:0] ERR_BASE  = 32'h0000_0F00;
  localparam logic [31:0] ERR_LAST  = 32'h0000_0FFF;
  localparam logic [31:0] DEAD_BASE = 32'h0000_1000;

  logic [31:0] mem [WORDS];
  wb_rsp_t     rsp_q = '0;
  logic [31:0] lfsr = SEED;
  logic [31:0] lfsr_1;
  logic [31:0] lfsr_2;
  logic        busy = 1'b0;
  logic [1:0]  wait_cnt = 2'd0;
  logic [7:0]  idx;
  logic        in_err;
  logic [31:0] merged;

  // One Galois step, polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // Every word gets a value built from its whole index.
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (i * 32'h9E37_79B1) ^ FILL_KEY;
    end
  end

  // Two bits are taken per cycle, so the state moves two steps.
  assign lfsr_1 = lfsr_next(lfsr);
  assign lfsr_2 = lfsr_next(lfsr_1);

  assign idx    = req_i.adr[9:2];
  assign in_err = ERR_ENABLE && (req_i.adr >= ERR_BASE) && (req_i.adr <= ERR_LAST);

  // Store data only lands in the lanes that sel picks.
  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < 4; b++) begin
      if (req_i.sel[b]) begin
        merged[8*b +: 8] = req_i.dat[8*b +: 8];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slave response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A new cycle draws 0 to 3 extra wait states, so the answer takes 1 to 4 cycles.
  // The response register blocks a restart in the cycle where ack is still high.
  always @(posedge clk) begin
    if (rst) begin
      rsp_q    <= '0;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
      lfsr     <= SEED;
    end else begin
      rsp_q.ack <= 1'b0;
      rsp_q.err <= 1'b0;
      if (!(req_i.cyc && req_i.stb)) begin
        busy <= 1'b0;
      end else if (!busy && !rsp_q.ack && !rsp_q.err) begin
        busy     <= 1'b1;
        wait_cnt <= {lfsr_1[0], lfsr[0]};
        lfsr     <= lfsr_2;
      end else if (busy && wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else if (busy && req_i.adr < DEAD_BASE) begin
        busy <= 1'b0;
        if (in_err) begin
          rsp_q.err <= 1'b1;
        end else begin
          rsp_q.ack <= 1'b1;
          if (req_i.we) begin
            mem[idx] <= merged;
          end else begin
            rsp_q.dat <= mem[idx];
          end
        end
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire
